//--- src/cop0_pkg.sv
// Coprocessor-0 register numbers, word and address types, instruction fields, decoded request
package cop0_pkg;

  typedef logic [31:0] word_t;       // Data word and register width
  typedef logic [4:0]  reg_addr_t;   // Coprocessor register number
  typedef logic [5:0]  opcode_t;     // Major opcode field
  typedef logic [4:0]  subop_t;      // rs field, selects MFC0/MTC0/CO
  typedef logic [5:0]  funct_t;      // Function field for CO ops

  // Register file map
  localparam reg_addr_t REG_BADVADDR = 5'd8;
  localparam reg_addr_t REG_STATUS   = 5'd12;
  localparam reg_addr_t REG_CAUSE    = 5'd13;
  localparam reg_addr_t REG_EPC      = 5'd14;

  // Instruction patterns
  localparam opcode_t OP_COP0 = 6'b010000;
  localparam subop_t  RS_MFC0 = 5'b00000;   // Move from coprocessor
  localparam subop_t  RS_MTC0 = 5'b00100;   // Move to coprocessor
  localparam subop_t  RS_CO   = 5'b10000;   // CO bit set, funct valid
  localparam funct_t  FN_RFE  = 6'b010000;  // Return from exception

  // Field positions in the instruction word
  localparam int OPCODE_MSB = 31;
  localparam int OPCODE_LSB = 26;
  localparam int RS_MSB     = 25;
  localparam int RS_LSB     = 21;
  localparam int RD_MSB     = 15;
  localparam int RD_LSB     = 11;
  localparam int FUNCT_MSB  = 5;
  localparam int FUNCT_LSB  = 0;

  // Status layout
  localparam int STATUS_IEC       = 0;  // Current interrupt enable
  localparam int STATUS_STACK_MSB = 5;  // Top of KU/IE stack

  // Decoded request, at most one of rd_en/wr_en/rfe set
  typedef struct packed {
    logic      rd_en;   // MFC0
    logic      wr_en;   // MTC0
    logic      rfe;     // Pop status stack
    reg_addr_t addr;    // rd field
  } cop0_req_t;

endpackage

//--- src/exc_pkg.sv
// Cause vector layout, interrupt line count, exception codes and stage exception report
package exc_pkg;

  typedef logic [31:0] cause_t;    // Cause vector, same layout as cause register
  typedef logic [4:0]  exc_code_t; // ExcCode field value

  localparam int NUM_HW_IRQ = 6;   // Hardware interrupt lines

  // Cause vector fields
  localparam int CAUSE_IP_MSB    = 15;  // Top of all pending bits
  localparam int CAUSE_IP_LSB    = 8;   // Bottom of all pending bits
  localparam int CAUSE_HW_LSB    = 10;  // Hardware pending bits start here
  localparam int CAUSE_SW_LSB    = 8;   // Software pending, two bits
  localparam int CAUSE_EXC_MSB   = 6;
  localparam int CAUSE_EXC_LSB   = 2;

  // Exception codes
  localparam exc_code_t EXC_INT  = 5'd0;   // Interrupt
  localparam exc_code_t EXC_MOD  = 5'd1;   // TLB modified
  localparam exc_code_t EXC_ADEL = 5'd4;   // Address error, load/fetch
  localparam exc_code_t EXC_ADES = 5'd5;   // Address error, store
  localparam exc_code_t EXC_IBE  = 5'd6;   // Bus error, fetch
  localparam exc_code_t EXC_DBE  = 5'd7;   // Bus error, data
  localparam exc_code_t EXC_SYS  = 5'd8;   // Syscall
  localparam exc_code_t EXC_BP   = 5'd9;   // Breakpoint
  localparam exc_code_t EXC_RI   = 5'd10;  // Reserved instruction
  localparam exc_code_t EXC_CPU  = 5'd11;  // Coprocessor unusable
  localparam exc_code_t EXC_OV   = 5'd12;  // Arithmetic overflow

  // One report per pipeline stage
  typedef struct packed {
    logic      valid;   // Stage has an exception
    exc_code_t code;    // Its code
  } stage_exc_t;

endpackage

//--- src/cop0_decode.sv
// COP0 instruction decoder producing read, write and rfe requests
`timescale 1ns/1ps

module cop0_decode (
  input  cop0_pkg::word_t     instr,        // Instruction word from pipeline
  input  logic                instr_valid,  // Word is a live instruction
  output cop0_pkg::cop0_req_t req           // Decoded request
);

  cop0_pkg::opcode_t   opcode;
  cop0_pkg::subop_t    subop;
  cop0_pkg::funct_t    funct;
  cop0_pkg::reg_addr_t rd;

  logic is_cop0;   // Major opcode match
  logic is_mfc0;
  logic is_mtc0;
  logic is_rfe;

  // Field slicing
  assign opcode = instr[cop0_pkg::OPCODE_MSB:cop0_pkg::OPCODE_LSB];
  assign subop  = instr[cop0_pkg::RS_MSB:cop0_pkg::RS_LSB];
  assign funct  = instr[cop0_pkg::FUNCT_MSB:cop0_pkg::FUNCT_LSB];
  assign rd     = instr[cop0_pkg::RD_MSB:cop0_pkg::RD_LSB];

  assign is_cop0 = instr_valid && (opcode == cop0_pkg::OP_COP0);  // Gate with valid

  // rs field picks the transfer direction
  assign is_mfc0 = is_cop0 && (subop == cop0_pkg::RS_MFC0);
  assign is_mtc0 = is_cop0 && (subop == cop0_pkg::RS_MTC0);

  // RFE needs CO bit and its funct
  assign is_rfe  = is_cop0 && (subop == cop0_pkg::RS_CO) &&
                   (funct == cop0_pkg::FN_RFE);

  // Patterns are disjoint on rs so one flag at most
  always_comb begin
    req       = '0;
    req.rd_en = is_mfc0;
    req.wr_en = is_mtc0;
    req.rfe   = is_rfe;
    req.addr  = rd;        // Register number from rd
  end

endmodule

//--- src/irq_collect.sv
// Interrupt synchronizer and cause vector merge of hardware lines and stage reports
`timescale 1ns/1ps

module irq_collect (
  input  logic                          clk,
  input  logic                          resetn,
  input  logic [exc_pkg::NUM_HW_IRQ-1:0] hw_irq,      // Async interrupt lines
  input  exc_pkg::stage_exc_t           stage1_exc,  // Earlier stage report
  input  exc_pkg::stage_exc_t           stage2_exc,  // Later stage report
  output exc_pkg::cause_t               cause        // Merged cause vector
);

  logic [exc_pkg::NUM_HW_IRQ-1:0] irq_meta;   // First sync stage
  logic [exc_pkg::NUM_HW_IRQ-1:0] irq_sync;   // Second sync stage
  exc_pkg::exc_code_t             exc_code;   // Selected stage code
  exc_pkg::cause_t                hw_part;
  exc_pkg::cause_t                exc_part;

  // Two-flop synchronizer, 2 cycle latency
  always_ff @(posedge clk) begin
    if (!resetn) begin
      irq_meta <= '0;
      irq_sync <= '0;
    end else begin
      irq_meta <= hw_irq;
      irq_sync <= irq_meta;
    end
  end

  // Stage 2 is older in program order, so it wins
  always_comb begin
    if (stage2_exc.valid)
      exc_code = stage2_exc.code;
    else if (stage1_exc.valid)
      exc_code = stage1_exc.code;
    else
      exc_code = '0;                     // No report, interrupt code
  end

  // Place fields into the cause layout
  always_comb begin
    hw_part  = '0;
    exc_part = '0;
    hw_part[exc_pkg::CAUSE_HW_LSB +: exc_pkg::NUM_HW_IRQ] = irq_sync;  // IP7..IP2
    exc_part[exc_pkg::CAUSE_EXC_MSB:exc_pkg::CAUSE_EXC_LSB] = exc_code;
  end

  assign cause = hw_part | exc_part;   // Software bits stay zero here

endmodule

//--- src/cop0_regs.sv
// COP0 register file: epc, cause, status, badvaddr, read port, read stall, exception detect
`timescale 1ns/1ps

module cop0_regs (
  input  logic                clk,
  input  logic                resetn,
  input  cop0_pkg::cop0_req_t req,          // Decoded request
  input  cop0_pkg::word_t     fromcpu,      // MTC0 data
  input  exc_pkg::cause_t     cause_in,     // Live cause vector
  input  cop0_pkg::word_t     epc_in,       // PC of faulting instruction
  input  cop0_pkg::word_t     badvaddr_in,  // Faulting address
  input  logic                badvaddr_we,  // Load badvaddr_in
  output cop0_pkg::word_t     tocpu,        // MFC0 data, one cycle late
  output logic                stalled,      // Hold pipeline for read
  output logic                exception,    // Take interrupt now
  output cop0_pkg::word_t     status        // Status register
);

  cop0_pkg::word_t epc_q;
  cop0_pkg::word_t cause_q;
  cop0_pkg::word_t badvaddr_q;
  cop0_pkg::word_t rd_data;    // Read mux output

  logic wr_epc;
  logic wr_cause;
  logic wr_status;
  logic wr_badvaddr;
  logic stall_q;               // Set in the cycle after a stall
  logic [7:0] irq_pending;     // Unmasked pending lines

  // Write strobes per register
  assign wr_epc      = req.wr_en && (req.addr == cop0_pkg::REG_EPC);
  assign wr_cause    = req.wr_en && (req.addr == cop0_pkg::REG_CAUSE);
  assign wr_status   = req.wr_en && (req.addr == cop0_pkg::REG_STATUS);
  assign wr_badvaddr = req.wr_en && (req.addr == cop0_pkg::REG_BADVADDR);

  // Interrupt request, pending and masked and globally enabled
  assign irq_pending = cause_in[exc_pkg::CAUSE_IP_MSB:exc_pkg::CAUSE_IP_LSB] &
                       status[exc_pkg::CAUSE_IP_MSB:exc_pkg::CAUSE_IP_LSB];
  assign exception   = (|irq_pending) && status[cop0_pkg::STATUS_IEC];

  // EPC, write beats exception capture
  always_ff @(posedge clk) begin
    if (!resetn)
      epc_q <= '0;
    else if (wr_epc)
      epc_q <= fromcpu;
    else if (exception)
      epc_q <= epc_in;                    // Save return PC
  end

  // Cause follows the live vector unless written
  always_ff @(posedge clk) begin
    if (!resetn)
      cause_q <= '0;
    else if (wr_cause)
      cause_q <= fromcpu;
    else
      cause_q <= cause_in;
  end

  // Status with the KU/IE three-level stack
  always_ff @(posedge clk) begin
    if (!resetn) begin
      status <= '0;
    end else if (wr_status) begin
      status <= fromcpu;
    end else if (exception) begin
      // Push, new level enters as kernel with interrupts off
      status[cop0_pkg::STATUS_STACK_MSB:0] <=
        {status[cop0_pkg::STATUS_STACK_MSB-2:0], 2'b00};
    end else if (req.rfe) begin
      // Pop, old level keeps its copy
      status[cop0_pkg::STATUS_STACK_MSB-2:0] <=
        status[cop0_pkg::STATUS_STACK_MSB:2];
    end
  end

  // Bad address, software write wins
  always_ff @(posedge clk) begin
    if (!resetn)
      badvaddr_q <= '0;
    else if (wr_badvaddr)
      badvaddr_q <= fromcpu;
    else if (badvaddr_we)
      badvaddr_q <= badvaddr_in;
  end

  // Read mux, unmapped numbers fall back to status
  always_comb begin
    case (req.addr)
      cop0_pkg::REG_EPC:      rd_data = epc_q;
      cop0_pkg::REG_CAUSE:    rd_data = cause_q;
      cop0_pkg::REG_BADVADDR: rd_data = badvaddr_q;
      default:                rd_data = status;
    endcase
  end

  // Registered read port, holds between reads
  always_ff @(posedge clk) begin
    if (!resetn)
      tocpu <= '0;
    else if (req.rd_en)
      tocpu <= rd_data;
  end

  // One-cycle stall, held repeat sees stall_q and passes
  always_ff @(posedge clk) begin
    if (!resetn)
      stall_q <= 1'b0;
    else
      stall_q <= stalled;
  end

  assign stalled = stall_q ? 1'b0 : req.rd_en;

endmodule

//--- src/cop0_top.sv
// Coprocessor-0 top level joining decoder, cause collector and register file
`timescale 1ns/1ps

module cop0_top (
  input  logic                           clk,
  input  logic                           resetn,
  input  cop0_pkg::word_t                instr,        // Current instruction
  input  logic                           instr_valid,
  input  cop0_pkg::word_t                fromcpu,      // MTC0 source data
  input  cop0_pkg::word_t                epc_in,
  input  cop0_pkg::word_t                badvaddr_in,
  input  logic                           badvaddr_we,
  input  logic [exc_pkg::NUM_HW_IRQ-1:0] hw_irq,       // External interrupts
  input  exc_pkg::stage_exc_t            stage1_exc,
  input  exc_pkg::stage_exc_t            stage2_exc,
  output cop0_pkg::word_t                tocpu,        // MFC0 result
  output logic                           stalled,
  output logic                           exception,
  output cop0_pkg::word_t                status
);

  cop0_pkg::cop0_req_t req;     // Decoder to register file
  exc_pkg::cause_t     cause;   // Collector to register file

  cop0_decode decode_i (
    .instr       (instr),
    .instr_valid (instr_valid),
    .req         (req)
  );

  // Sync and merge of all cause sources
  irq_collect irq_i (
    .clk        (clk),
    .resetn     (resetn),
    .hw_irq     (hw_irq),
    .stage1_exc (stage1_exc),
    .stage2_exc (stage2_exc),
    .cause      (cause)
  );

  cop0_regs regs_i (
    .clk         (clk),
    .resetn      (resetn),
    .req         (req),
    .fromcpu     (fromcpu),
    .cause_in    (cause),
    .epc_in      (epc_in),
    .badvaddr_in (badvaddr_in),
    .badvaddr_we (badvaddr_we),
    .tocpu       (tocpu),
    .stalled     (stalled),
    .exception   (exception),
    .status      (status)
  );

endmodule

//--- sim/cop0_tb.sv
// Testbench for cop0_top with clock, LCG, register reference model, directed and random stimulus
`timescale 1ns/1ps

module cop0_tb;

  localparam int NUM_RANDOM  = 50;
  localparam int CYCLE_LIMIT = 2000;  // Tests take under 200 cycles, tenfold margin

  typedef struct packed {
    logic                           valid;        // instr_valid
    logic                           rd;           // MFC0
    logic                           wr;           // MTC0
    logic                           rfe;
    cop0_pkg::reg_addr_t            addr;
    cop0_pkg::word_t                fromcpu;
    cop0_pkg::word_t                epc_in;
    cop0_pkg::word_t                badvaddr_in;
    logic                           badvaddr_we;
    logic [exc_pkg::NUM_HW_IRQ-1:0] hw_irq;
    exc_pkg::stage_exc_t            stage1;
    exc_pkg::stage_exc_t            stage2;
  } stim_t;

  typedef struct packed {
    cop0_pkg::word_t status;
    cop0_pkg::word_t epc;
    cop0_pkg::word_t cause;
    cop0_pkg::word_t badvaddr;
    cop0_pkg::word_t tocpu;
    logic            stall_seen;   // Read stalled last cycle
    logic [5:0]      sync1;        // Interrupt delay line
    logic [5:0]      sync2;
  } model_t;

  logic            clk;
  logic            resetn;
  stim_t           stim;           // DUT inputs driven on falling edges
  model_t          model;
  cop0_pkg::word_t instr;
  cop0_pkg::word_t tocpu;
  cop0_pkg::word_t status;
  logic            stalled;
  logic            exception;
  logic [31:0]     lcg_state;
  int              value_errors;   // Directed value checks
  int              other_errors;
  int              model_errors;   // Cycle compare against model
  int              cycles = 0;

  assign instr = make_instr(stim);

  cop0_top dut_i (
    .clk         (clk),
    .resetn      (resetn),
    .instr       (instr),
    .instr_valid (stim.valid),
    .fromcpu     (stim.fromcpu),
    .epc_in      (stim.epc_in),
    .badvaddr_in (stim.badvaddr_in),
    .badvaddr_we (stim.badvaddr_we),
    .hw_irq      (stim.hw_irq),
    .stage1_exc  (stim.stage1),
    .stage2_exc  (stim.stage2),
    .tocpu       (tocpu),
    .stalled     (stalled),
    .exception   (exception),
    .status      (status)
  );

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Encode the request as a MIPS word with an SLL nop when idle
  function automatic cop0_pkg::word_t make_instr(stim_t s);
    cop0_pkg::word_t w;
    w = 32'h0000_0000;
    if (s.rd)
      w = {cop0_pkg::OP_COP0, cop0_pkg::RS_MFC0, 5'd2, s.addr, 11'd0};
    else if (s.wr)
      w = {cop0_pkg::OP_COP0, cop0_pkg::RS_MTC0, 5'd3, s.addr, 11'd0};
    else if (s.rfe)
      w = {cop0_pkg::OP_COP0, cop0_pkg::RS_CO, 15'd0, cop0_pkg::FN_RFE};
    return w;
  endfunction

  // Lines two cycles old and stage 2 code ahead of stage 1
  function automatic exc_pkg::cause_t predict_cause(model_t m, stim_t s);
    exc_pkg::cause_t c;
    c = '0;
    c[15:10] = m.sync2;
    if (s.stage2.valid)
      c[6:2] = s.stage2.code;
    else if (s.stage1.valid)
      c[6:2] = s.stage1.code;
    return c;
  endfunction

  function automatic logic predict_exception(model_t m, stim_t s);
    exc_pkg::cause_t c;
    c = predict_cause(m, s);
    return (|(c[15:8] & m.status[15:8])) && m.status[0];
  endfunction

  // Register state after one clock edge
  function automatic model_t model_step(model_t m, stim_t s);
    model_t n;
    logic   rd;
    logic   wr;
    logic   exc;
    n   = m;
    rd  = s.valid && s.rd;
    wr  = s.valid && s.wr;
    exc = predict_exception(m, s);
    n.sync1 = s.hw_irq;
    n.sync2 = m.sync1;
    n.cause = (wr && s.addr == cop0_pkg::REG_CAUSE) ? s.fromcpu : predict_cause(m, s);
    if (wr && s.addr == cop0_pkg::REG_EPC)
      n.epc = s.fromcpu;
    else if (exc)
      n.epc = s.epc_in;                              // Return PC captured
    if (wr && s.addr == cop0_pkg::REG_STATUS)
      n.status = s.fromcpu;
    else if (exc)
      n.status[5:0] = {m.status[3:0], 2'b00};        // Push
    else if (s.valid && s.rfe)
      n.status[3:0] = m.status[5:2];                 // Pop
    if (wr && s.addr == cop0_pkg::REG_BADVADDR)
      n.badvaddr = s.fromcpu;
    else if (s.badvaddr_we)
      n.badvaddr = s.badvaddr_in;
    if (rd) begin
      case (s.addr)
        cop0_pkg::REG_EPC:      n.tocpu = m.epc;
        cop0_pkg::REG_CAUSE:    n.tocpu = m.cause;
        cop0_pkg::REG_BADVADDR: n.tocpu = m.badvaddr;
        default:                n.tocpu = m.status;
      endcase
    end
    n.stall_seen = rd && !m.stall_seen;
    return n;
  endfunction

  task automatic check_value(input string name, input cop0_pkg::word_t got,
                             input cop0_pkg::word_t exp, inout int count);
    assert (got === exp) else begin
      count++;
      $display("FAIL %0t ns %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    assert (cond) else begin
      other_errors++;
      $display("Error at %0t ns: %s", $time, msg);
    end
  endtask

  task automatic write_reg(input cop0_pkg::reg_addr_t addr, input cop0_pkg::word_t data);
    stim.rd      = 1'b0;
    stim.rfe     = 1'b0;
    stim.wr      = 1'b1;
    stim.addr    = addr;
    stim.fromcpu = data;
    @(negedge clk);
    stim.wr = 1'b0;
  endtask

  // Hold the read until stalled drops and then pick up tocpu
  task automatic read_reg(input cop0_pkg::reg_addr_t addr, output cop0_pkg::word_t val);
    int stall_cycles;
    stall_cycles = 0;
    stim.wr   = 1'b0;
    stim.rfe  = 1'b0;
    stim.rd   = 1'b1;
    stim.addr = addr;
    @(posedge clk);
    while (stalled) begin
      stall_cycles++;
      @(posedge clk);
    end
    check_true(stall_cycles == 1, "read did not stall for exactly one cycle");
    @(negedge clk);
    val     = tocpu;
    stim.rd = 1'b0;
  endtask

  task automatic do_rfe();
    stim.rd   = 1'b0;
    stim.wr   = 1'b0;
    stim.rfe  = 1'b1;
    stim.addr = '0;
    @(negedge clk);
    stim.rfe = 1'b0;
  endtask

  task automatic expect_no_exception(input int n);
    repeat (n) begin
      @(posedge clk);
      check_true(!exception, "exception raised while masked or disabled");
    end
    @(negedge clk);
  endtask

  task automatic test_reset_reads();
    cop0_pkg::word_t got;
    read_reg(cop0_pkg::REG_BADVADDR, got);
    check_value("badvaddr", got, '0, value_errors);
    read_reg(cop0_pkg::REG_STATUS, got);
    check_value("status", got, '0, value_errors);
    read_reg(cop0_pkg::REG_CAUSE, got);
    check_value("cause", got, '0, value_errors);
    read_reg(cop0_pkg::REG_EPC, got);
    check_value("epc", got, '0, value_errors);
    read_reg(5'd5, got);                             // Unmapped number falls back to status
    check_value("status", got, '0, value_errors);
  endtask

  task automatic test_random_access();
    cop0_pkg::word_t     shadow_status;
    cop0_pkg::word_t     shadow_epc;
    cop0_pkg::word_t     shadow_bad;
    cop0_pkg::word_t     r;
    cop0_pkg::word_t     data;
    cop0_pkg::word_t     got;
    cop0_pkg::reg_addr_t addr;
    shadow_status = '0;
    shadow_epc    = '0;
    shadow_bad    = '0;
    for (int i = 0; i < NUM_RANDOM; i++) begin
      r    = next_random();
      data = next_random();
      case (r[29:28])                                // Upper LCG bits spread better
        2'd0:    addr = cop0_pkg::REG_EPC;
        2'd1:    addr = cop0_pkg::REG_BADVADDR;
        default: addr = cop0_pkg::REG_STATUS;
      endcase
      if (r[31]) begin
        read_reg(addr, got);
        if (addr == cop0_pkg::REG_EPC)
          check_value("epc", got, shadow_epc, value_errors);
        else if (addr == cop0_pkg::REG_BADVADDR)
          check_value("badvaddr", got, shadow_bad, value_errors);
        else
          check_value("status", got, shadow_status, value_errors);
      end else begin
        if (addr == cop0_pkg::REG_STATUS)
          data[0] = 1'b0;                            // Interrupts stay off
        write_reg(addr, data);
        if (addr == cop0_pkg::REG_EPC)
          shadow_epc = data;
        else if (addr == cop0_pkg::REG_BADVADDR)
          shadow_bad = data;
        else
          shadow_status = data;
      end
    end
  endtask

  task automatic test_masked_irq();
    cop0_pkg::word_t got;
    write_reg(cop0_pkg::REG_STATUS, 32'h0000_0400);  // IP2 mask with IE off
    stim.hw_irq = 6'b000001;
    expect_no_exception(4);
    read_reg(cop0_pkg::REG_CAUSE, got);
    check_value("cause", got, 32'h0000_0400, value_errors);
    stim.stage1 = {1'b1, exc_pkg::EXC_OV};
    read_reg(cop0_pkg::REG_CAUSE, got);
    check_value("cause", got, 32'h0000_0430, value_errors);  // Code 12 in 6:2
    stim.stage2 = {1'b1, exc_pkg::EXC_SYS};
    read_reg(cop0_pkg::REG_CAUSE, got);
    check_value("cause", got, 32'h0000_0420, value_errors);  // Stage 2 code 8
    write_reg(cop0_pkg::REG_STATUS, 32'h0000_0001);  // IE on with no mask
    expect_no_exception(3);
    write_reg(cop0_pkg::REG_STATUS, '0);
    stim.hw_irq = '0;
    stim.stage1 = '0;
    stim.stage2 = '0;
    repeat (4) @(negedge clk);                       // Let the sync chain drain
  endtask

  task automatic test_exception_rfe();
    cop0_pkg::word_t got;
    cop0_pkg::word_t epc_val;
    int              waited;
    epc_val      = next_random();
    stim.epc_in  = epc_val;
    write_reg(cop0_pkg::REG_STATUS, 32'h0000_040D);  // IP2 mask and stack 00_11_01
    stim.hw_irq = 6'b000001;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (!exception && waited < 10);
    check_true(exception, "interrupt never raised exception");
    check_true(waited == 3, "exception did not follow the interrupt after the sync delay");
    @(posedge clk);
    check_true(!exception, "exception lasted more than one cycle");
    @(negedge clk);
    stim.epc_in = next_random();                     // Must not load any more
    read_reg(cop0_pkg::REG_EPC, got);
    check_value("epc", got, epc_val, value_errors);
    read_reg(cop0_pkg::REG_STATUS, got);
    check_value("status", got, 32'h0000_0434, value_errors);
    stim.hw_irq = '0;
    repeat (4) @(negedge clk);
    do_rfe();
    read_reg(cop0_pkg::REG_STATUS, got);
    check_value("status", got, 32'h0000_043D, value_errors);
    expect_no_exception(3);
    write_reg(cop0_pkg::REG_STATUS, '0);
  endtask

  task automatic test_badvaddr();
    cop0_pkg::word_t got;
    cop0_pkg::word_t hw_addr;
    cop0_pkg::word_t sw_addr;
    hw_addr = next_random();
    sw_addr = next_random();
    stim.badvaddr_in = hw_addr;
    stim.badvaddr_we = 1'b1;
    @(negedge clk);
    stim.badvaddr_we = 1'b0;
    read_reg(cop0_pkg::REG_BADVADDR, got);
    check_value("badvaddr", got, hw_addr, value_errors);
    stim.badvaddr_in = next_random();
    stim.badvaddr_we = 1'b1;                         // Collides with MTC0 below
    write_reg(cop0_pkg::REG_BADVADDR, sw_addr);
    stim.badvaddr_we = 1'b0;
    read_reg(cop0_pkg::REG_BADVADDR, got);
    check_value("badvaddr", got, sw_addr, value_errors);
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Compare against the model on every edge out of reset
  always @(posedge clk) begin
    if (!resetn) begin
      model = '0;
    end else begin
      check_value("tocpu", tocpu, model.tocpu, model_errors);
      check_value("status", status, model.status, model_errors);
      check_value("stalled", {31'd0, stalled},
                  {31'd0, stim.valid && stim.rd && !model.stall_seen}, model_errors);
      check_value("exception", {31'd0, exception},
                  {31'd0, predict_exception(model, stim)}, model_errors);
      model = model_step(model, stim);
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Errors: %0d model, %0d value, %0d other",
               model_errors, value_errors, other_errors);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  initial begin
    resetn       = 1'b0;
    stim         = '0;
    lcg_state    = 32'd13673;
    value_errors = 0;
    other_errors = 0;
    model_errors = 0;
    repeat (3) @(posedge clk);                       // Three rising edges in reset
    @(negedge clk);
    resetn      = 1'b1;
    stim.valid  = 1'b1;
    stim.epc_in = next_random();
    test_reset_reads();
    test_random_access();
    test_masked_irq();
    test_exception_rfe();
    test_badvaddr();
    repeat (2) @(negedge clk);
    $display("Errors: %0d model, %0d value, %0d other",
             model_errors, value_errors, other_errors);
    if (model_errors + value_errors + other_errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- src.f
src/cop0_pkg.sv
src/exc_pkg.sv
src/cop0_decode.sv
src/irq_collect.sv
src/cop0_regs.sv
src/cop0_top.sv
sim/cop0_tb.sv

//--- Makefile
# Verilator build and run of the coprocessor-0 testbench
VERILATOR ?= verilator
TOP       ?= cop0_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= STATUS: PASS

.PHONY: simulate clean

# Build, run, and fail unless the pass line shows up
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q '^$(PASS_MSG)$$'

clean:
	rm -rf $(OBJ_DIR)
